/* hdl/divsqrt_defines.svh */
/*
 * Widths and iteration count shared by the divide/sqrt unit.
 * DS_ITERS must equal DS_RESW: one result bit per iteration.
 * DS_OPW must be exactly twice DS_RESW for the divider split.
 */
`ifndef DIVSQRT_DEFINES_SVH
`define DIVSQRT_DEFINES_SVH

// Operand word, holds both divider halves or the full radicand
`define DS_OPW 32

// Quotient and root width
`define DS_RESW 16

// Iterations per operation, one result bit each
`define DS_ITERS 16

// Request tag, returned untouched with the response
`define DS_TAGW 4

`endif

/* hdl/divsqrt_pkg.sv */
/*
 * Types for the multi-cycle divide/sqrt unit.
 * The operand word is a union: divider halves or one radicand.
 * Field order of the structs sets the packed bit layout.
 */
`include "divsqrt_defines.svh"

package divsqrt_pkg;

  // Operation select, one bit
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } ds_op_e;

  // Divider view, dividend in the upper half
  typedef struct packed {
    logic [`DS_RESW-1:0] dividend;
    logic [`DS_RESW-1:0] divisor;
  } ds_div_ops_t;

  // Same word read two ways
  typedef union packed {
    ds_div_ops_t        div;
    logic [`DS_OPW-1:0] radicand;
  } ds_operand_u;

  // dz: divide by zero, nx: inexact
  typedef struct packed {
    logic dz;
    logic nx;
  } ds_status_t;

  typedef struct packed {
    ds_op_e              op;
    ds_operand_u         operand;
    logic [`DS_TAGW-1:0] tag;
  } ds_req_t;

  typedef struct packed {
    logic [`DS_RESW-1:0] result;
    ds_status_t          status;
    logic [`DS_TAGW-1:0] tag;
  } ds_rsp_t;

endpackage

/* hdl/div_iter.sv */
/*
 * Radix-2 restoring divider, unsigned, one quotient bit per cycle.
 * Result and done appear one cycle after the last iteration.
 * Zero divisor returns all ones with dz set. kill_i aborts.
 */
`timescale 1ns/1ns
`include "divsqrt_defines.svh"

module div_iter import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  logic                kill_i,
  input  ds_operand_u         operand_i,
  output logic                done_o,
  output logic [`DS_RESW-1:0] quot_o,
  output ds_status_t          status_o
);

  localparam int unsigned CntW = $clog2(`DS_ITERS);

  logic [CntW-1:0]     cnt_q;
  logic                run_q;
  logic                fin_q;
  logic                done_q;
  logic [`DS_RESW-1:0] rem_q;
  logic [`DS_RESW-1:0] dvd_q;
  logic [`DS_RESW-1:0] dsr_q;
  logic [`DS_RESW-1:0] quot_q;
  ds_status_t          status_q;
  logic [`DS_RESW:0]   shifted;
  logic [`DS_RESW+1:0] diff;
  logic                q_bit;
  logic                dz;

  // ------------------------------------------------------------------------
  // Trial subtraction
  // ------------------------------------------------------------------------
  // Next dividend bit enters the partial remainder
  assign shifted = {rem_q, dvd_q[`DS_RESW-1]};
  assign diff    = {1'b0, shifted} - {2'b00, dsr_q};
  // No borrow means the divisor fits
  assign q_bit   = ~diff[`DS_RESW+1];
  assign dz      = (dsr_q == '0);

  // Sequencing, fin marks the cycle after the last iteration
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      fin_q  <= 1'b0;
      done_q <= 1'b0;
    end else if (kill_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      fin_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= fin_q;
      fin_q  <= 1'b0;
      if (start_i) begin
        cnt_q <= '0;
        run_q <= 1'b1;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CntW'(`DS_ITERS - 1)) begin
          run_q <= 1'b0;
          fin_q <= 1'b1;
        end
      end
    end
  end

  // Datapath, quotient bits shift in where dividend bits leave
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q <= '0;
      dvd_q <= operand_i.div.dividend;
      dsr_q <= operand_i.div.divisor;
    end else if (run_q) begin
      rem_q <= q_bit ? diff[`DS_RESW-1:0] : shifted[`DS_RESW-1:0];
      dvd_q <= {dvd_q[`DS_RESW-2:0], q_bit};
    end
    if (fin_q) begin
      quot_q      <= dz ? '1 : dvd_q;
      status_q.dz <= dz;
      status_q.nx <= ~dz & (|rem_q);
    end
  end

  assign done_o   = done_q;
  assign quot_o   = quot_q;
  assign status_o = status_q;

endmodule

/* hdl/sqrt_iter.sv */
/*
 * Restoring digit-by-digit square root, floor of a 32-bit radicand.
 * Two radicand bits per cycle, result one cycle after the last step.
 * dz is never set; nx flags a nonzero remainder. kill_i aborts.
 */
`timescale 1ns/1ns
`include "divsqrt_defines.svh"

module sqrt_iter import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  logic                kill_i,
  input  ds_operand_u         operand_i,
  output logic                done_o,
  output logic [`DS_RESW-1:0] root_o,
  output ds_status_t          status_o
);

  localparam int unsigned CntW = $clog2(`DS_ITERS);

  logic [CntW-1:0]     cnt_q;
  logic                run_q;
  logic                fin_q;
  logic                done_q;
  logic [`DS_OPW-1:0]  rad_q;
  logic [`DS_RESW-1:0] root_q;
  logic [`DS_RESW+1:0] rem_q;
  logic [`DS_RESW-1:0] res_q;
  ds_status_t          status_q;
  logic [`DS_RESW+3:0] rem_sh;
  logic [`DS_RESW+3:0] trial;
  logic [`DS_RESW+3:0] diff;
  logic                ge;

  // ------------------------------------------------------------------------
  // Trial subtraction of 4*root + 1
  // ------------------------------------------------------------------------
  // Remainder stays below 2*root + 1, so 18 bits suffice
  assign rem_sh = {rem_q, rad_q[`DS_OPW-1 -: 2]};
  assign trial  = {2'b00, root_q, 2'b01};
  assign diff   = rem_sh - trial;
  assign ge     = (rem_sh >= trial);

  // Sequencing, same step count as the divider
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      fin_q  <= 1'b0;
      done_q <= 1'b0;
    end else if (kill_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      fin_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= fin_q;
      fin_q  <= 1'b0;
      if (start_i) begin
        cnt_q <= '0;
        run_q <= 1'b1;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CntW'(`DS_ITERS - 1)) begin
          run_q <= 1'b0;
          fin_q <= 1'b1;
        end
      end
    end
  end

  // Datapath, radicand consumed from the top two bits at a time
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rad_q  <= operand_i.radicand;
      root_q <= '0;
      rem_q  <= '0;
    end else if (run_q) begin
      rad_q  <= {rad_q[`DS_OPW-3:0], 2'b00};
      root_q <= {root_q[`DS_RESW-2:0], ge};
      rem_q  <= ge ? diff[`DS_RESW+1:0] : rem_sh[`DS_RESW+1:0];
    end
    if (fin_q) begin
      res_q       <= root_q;
      status_q.dz <= 1'b0;
      status_q.nx <= |rem_q;
    end
  end

  assign done_o   = done_q;
  assign root_o   = res_q;
  assign status_o = status_q;

endmodule

/* hdl/divsqrt_ctrl.sv */
/*
 * IDLE/BUSY/HOLD control for the divide/sqrt engines.
 * One request in flight; a new one may enter in the consume cycle.
 * flush_i drops any result and aborts the running engine.
 */
`timescale 1ns/1ns
`include "divsqrt_defines.svh"

module divsqrt_ctrl import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  ds_req_t             req_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  output logic                div_start_o,
  output logic                sqrt_start_o,
  output logic                kill_o,
  output ds_operand_u         operand_o,
  input  logic                div_done_i,
  input  logic [`DS_RESW-1:0] div_quot_i,
  input  ds_status_t          div_status_i,
  input  logic                sqrt_done_i,
  input  logic [`DS_RESW-1:0] sqrt_root_i,
  input  ds_status_t          sqrt_status_i,
  output ds_rsp_t             rsp_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} fsm_state_e;

  fsm_state_e          state_q, state_d;
  logic                in_ready;
  logic                accept;
  logic                unit_done;
  logic                out_valid;
  logic                hold_result;
  logic                data_is_held;
  logic                unit_busy;
  ds_op_e              op_q;
  logic [`DS_TAGW-1:0] tag_q;
  logic [`DS_RESW-1:0] unit_result, held_result_q, result_d;
  ds_status_t          unit_status, held_status_q, status_d;

  // ------------------------------------------------------------------------
  // Engine start and result select
  // ------------------------------------------------------------------------
  // in_ready is already low under flush
  assign accept       = in_valid_i & in_ready;
  assign div_start_o  = accept & (req_i.op == OP_DIV);
  assign sqrt_start_o = accept & (req_i.op == OP_SQRT);
  assign operand_o    = req_i.operand;
  assign kill_o       = flush_i;

  // Registered op picks the engine that owns the result
  assign unit_done   = (op_q == OP_DIV) ? div_done_i : sqrt_done_i;
  assign unit_result = (op_q == OP_DIV) ? div_quot_i : sqrt_root_i;
  assign unit_status = (op_q == OP_DIV) ? div_status_i : sqrt_status_i;

  always_comb begin : ctrl_fsm
    in_ready     = 1'b0;
    out_valid    = 1'b0;
    hold_result  = 1'b0;
    data_is_held = 1'b0;
    unit_busy    = 1'b0;
    state_d      = state_q;
    unique case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        unit_busy = 1'b1;
        if (unit_done) begin
          out_valid = 1'b1;
          if (out_ready_i) begin
            // Consumed at once, next request may enter now
            state_d  = in_valid_i ? BUSY : IDLE;
            in_ready = 1'b1;
          end else begin
            hold_result = 1'b1;
            state_d     = HOLD;
          end
        end
      end
      HOLD: begin
        unit_busy    = 1'b1;
        data_is_held = 1'b1;
        out_valid    = 1'b1;
        if (out_ready_i) begin
          state_d  = in_valid_i ? BUSY : IDLE;
          in_ready = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush wins over everything above
    if (flush_i) begin
      in_ready  = 1'b0;
      out_valid = 1'b0;
      unit_busy = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      op_q    <= OP_DIV;
    end else begin
      state_q <= state_d;
      if (accept) begin
        op_q <= req_i.op;
      end
    end
  end

  // Tag and hold register, loaded on accept and on stall
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q <= req_i.tag;
    end
    if (hold_result) begin
      held_result_q <= unit_result;
      held_status_q <= unit_status;
    end
  end

  // Held data has priority
  assign result_d = data_is_held ? held_result_q : unit_result;
  assign status_d = data_is_held ? held_status_q : unit_status;

  assign rsp_o.result = result_d;
  assign rsp_o.status = status_d;
  assign rsp_o.tag    = tag_q;
  assign in_ready_o   = in_ready;
  assign out_valid_o  = out_valid;
  assign busy_o       = unit_busy;

endmodule

/* hdl/divsqrt_multi.sv */
/*
 * Multi-cycle unsigned divide and square root, valid/ready on both sides.
 * Fixed latency: out_valid_o rises 17 cycles after the accepting edge.
 * No pipeline registers; only one request is in flight at a time.
 */
`timescale 1ns/1ns
`include "divsqrt_defines.svh"

module divsqrt_multi import divsqrt_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  ds_req_t req_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  logic    flush_i,
  output ds_rsp_t rsp_o,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output logic    busy_o
);

  // Engine side wires
  logic                div_start, sqrt_start, kill;
  ds_operand_u         operand;
  logic                div_done, sqrt_done;
  logic [`DS_RESW-1:0] div_quot, sqrt_root;
  ds_status_t          div_status, sqrt_status;

  // ------------------------------------------------------------------------
  // Control, owns both handshakes
  // ------------------------------------------------------------------------
  divsqrt_ctrl ctrl_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .flush_i       (flush_i),
    .div_start_o   (div_start),
    .sqrt_start_o  (sqrt_start),
    .kill_o        (kill),
    .operand_o     (operand),
    .div_done_i    (div_done),
    .div_quot_i    (div_quot),
    .div_status_i  (div_status),
    .sqrt_done_i   (sqrt_done),
    .sqrt_root_i   (sqrt_root),
    .sqrt_status_i (sqrt_status),
    .rsp_o         (rsp_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .busy_o        (busy_o)
  );

  // Engines side by side, both see the same operand word
  div_iter div_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (div_start),
    .kill_i    (kill),
    .operand_i (operand),
    .done_o    (div_done),
    .quot_o    (div_quot),
    .status_o  (div_status)
  );

  sqrt_iter sqrt_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (sqrt_start),
    .kill_i    (kill),
    .operand_i (operand),
    .done_o    (sqrt_done),
    .root_o    (sqrt_root),
    .status_o  (sqrt_status)
  );

endmodule

/* verification/divsqrt_multi_chk.sv */
/*
 * Handshake and flush assertions, bound into the top level.
 * Assumes flush_i is never raised while a response waits.
 */
`timescale 1ns/1ns

module divsqrt_multi_chk import divsqrt_pkg::*; (
  input logic    clk_i,
  input logic    arst_n_i,
  input logic    flush_i,
  input logic    in_ready_i,
  input ds_rsp_t rsp_i,
  input logic    out_valid_i,
  input logic    out_ready_i,
  input logic    busy_i
);

  // Failures seen so far, read by the testbench
  int unsigned fail_cnt = 0;

  // ------------------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------------------
  // Waiting response holds its value
  rsp_stable_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i |=> $stable(rsp_i))
  else begin
    fail_cnt++;
    $error("rsp_o changed while waiting for out_ready_i");
  end

  // Valid stays up until consumed or flushed
  valid_held_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i || flush_i)
  else begin
    fail_cnt++;
    $error("out_valid_o dropped before the response was consumed");
  end

  // No new request while a result waits
  no_accept_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i |-> !in_ready_i)
  else begin
    fail_cnt++;
    $error("in_ready_o high while a response waits");
  end

  // Flush blanks both handshakes and leaves the unit idle
  flush_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |-> !out_valid_i && !in_ready_i ##1 !busy_i)
  else begin
    fail_cnt++;
    $error("flush did not blank the handshakes or clear busy");
  end

endmodule

/* verification/divsqrt_multi_tb.sv */
/*
 * Table-driven testbench for the divide/sqrt unit.
 * Inputs change on the rising edge, outputs are sampled on the falling edge.
 * Expected values are worked out by hand from the divide and floor sqrt rules.
 * Two table entries are flushed and must not answer.
 */
`timescale 1ns/1ns
`include "divsqrt_defines.svh"

module divsqrt_multi_tb
  import divsqrt_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int RST_CYCLES      = 5;
  localparam int NUM_TESTS       = 12;
  localparam int MAX_STALL       = 7;
  localparam int LATENCY         = `DS_ITERS + 1;
  localparam int QUIET           = LATENCY + 1;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (LATENCY + MAX_STALL + 4) + RST_CYCLES + 2;

  // One row of the stimulus table
  // A flush_at of 0 means no flush
  typedef struct packed {
    ds_op_e              op;
    logic [`DS_OPW-1:0]  operand;
    logic [`DS_TAGW-1:0] tag;
    logic [3:0]          stall;
    logic                rnd_stall;
    logic [4:0]          flush_at;
    logic [`DS_RESW-1:0] exp_result;
    ds_status_t          exp_status;
  } test_entry_t;

  logic        clk = 1'b0;
  logic        arst_n;
  ds_req_t     req;
  logic        in_valid;
  logic        in_ready;
  logic        flush;
  ds_rsp_t     rsp;
  logic        out_valid;
  logic        out_ready;
  logic        busy;
  test_entry_t tests [NUM_TESTS];
  int unsigned errors = 0;
  int unsigned rsp_count = 0;
  int unsigned exp_rsp_count = 0;
  int unsigned cur_test = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  divsqrt_multi divsqrt_multi_inst (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .flush_i     (flush),
    .rsp_o       (rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  // Handshake and flush assertions
  bind divsqrt_multi divsqrt_multi_chk chk_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .in_ready_i  (in_ready_o),
    .rsp_i       (rsp_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_i      (busy_o)
  );

  // Count every consumed response at the falling edge
  always @(negedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      rsp_count++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] test %0d %s: got %h, expected %h", cur_test, name, got, exp);
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------------
  // op, operand, tag, stall, random stall, flush_at, result, {dz, nx}
  task automatic load_table();
    // Division view has the dividend in the upper half
    tests[0]  = '{OP_DIV,  32'h0064_0007, 4'h1, 4'd0, 1'b0, 5'd0,  16'd14,    2'b01};
    tests[1]  = '{OP_DIV,  32'h0090_000C, 4'h2, 4'd0, 1'b0, 5'd0,  16'd12,    2'b00};
    tests[2]  = '{OP_DIV,  32'hFFFF_0001, 4'h3, 4'd2, 1'b0, 5'd0,  16'hFFFF,  2'b00};
    // Zero divisor gives all ones with dz
    tests[3]  = '{OP_DIV,  32'h04D2_0000, 4'h4, 4'd0, 1'b0, 5'd0,  16'hFFFF,  2'b10};
    tests[4]  = '{OP_SQRT, 32'h0000_0090, 4'h5, 4'd0, 1'b0, 5'd0,  16'd12,    2'b00};
    tests[5]  = '{OP_SQRT, 32'h0000_0002, 4'h6, 4'd0, 1'b1, 5'd0,  16'd1,     2'b01};
    tests[6]  = '{OP_SQRT, 32'hFFFF_FFFF, 4'h7, 4'd0, 1'b1, 5'd0,  16'hFFFF,  2'b01};
    // Aborted mid-run so no response is expected
    tests[7]  = '{OP_DIV,  32'h03E8_0003, 4'h8, 4'd0, 1'b0, 5'd3,  16'd333,   2'b01};
    // Flushed in the done cycle so the ready result is dropped
    tests[8]  = '{OP_SQRT, 32'h0000_0064, 4'hB, 4'd0, 1'b0, 5'd17, 16'd10,    2'b00};
    tests[9]  = '{OP_SQRT, 32'h000F_4240, 4'h9, 4'd0, 1'b1, 5'd0,  16'd1000,  2'b00};
    tests[10] = '{OP_DIV,  32'hC350_00FA, 4'hA, 4'd0, 1'b1, 5'd0,  16'd200,   2'b00};
    tests[11] = '{OP_DIV,  32'h0007_0009, 4'hF, 4'd3, 1'b0, 5'd0,  16'd0,     2'b01};
  endtask

  // ------------------------------------------------------------------------
  // One request from drive to consume
  // ------------------------------------------------------------------------
  task automatic run_test(input test_entry_t e, input int unsigned stall);
    ds_req_t     r;
    ds_rsp_t     first;
    int unsigned cycles;
    r.op               = e.op;
    r.operand.radicand = e.operand;
    r.tag              = e.tag;
    @(posedge clk);
    req       <= r;
    in_valid  <= 1'b1;
    out_ready <= (stall == 0);
    // Wait for in_ready_o
    cycles = 0;
    @(negedge clk);
    while (!in_ready && cycles < LATENCY + MAX_STALL) begin
      @(negedge clk);
      cycles++;
    end
    if (!in_ready) begin
      errors++;
      $display("Test %0d: request was never accepted", cur_test);
      return;
    end
    // Accepting edge
    @(posedge clk);
    in_valid <= 1'b0;
    if (e.flush_at != 0) begin
      @(negedge clk);
      check_value("busy_o", busy, 32'd1);
      repeat (e.flush_at) @(posedge clk);
      flush <= 1'b1;
      @(negedge clk);
      check_value("out_valid_o", out_valid, 32'd0);
      check_value("in_ready_o", in_ready, 32'd0);
      @(posedge clk);
      flush <= 1'b0;
      @(negedge clk);
      check_value("busy_o", busy, 32'd0);
      // Flushed request stays silent past its normal latency
      repeat (QUIET) begin
        @(negedge clk);
        check_value("out_valid_o", out_valid, 32'd0);
      end
      return;
    end
    // Count edges until out_valid_o
    cycles = 0;
    @(negedge clk);
    while (!out_valid && cycles < LATENCY + 4) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (!out_valid) begin
      errors++;
      $display("Test %0d: no response within %0d cycles", cur_test, LATENCY + 4);
      return;
    end
    check_value("out_valid_o latency", cycles, LATENCY);
    first = rsp;
    // Response must hold still under back-pressure
    for (int i = 0; i < stall; i++) begin
      check_value("out_valid_o", out_valid, 32'd1);
      check_value("in_ready_o", in_ready, 32'd0);
      @(posedge clk);
      if (i == stall - 1) begin
        out_ready <= 1'b1;
      end
      @(negedge clk);
      check_value("rsp_o", rsp, first);
    end
    check_value("busy_o", busy, 32'd1);
    check_value("rsp_o.result", rsp.result, e.exp_result);
    check_value("rsp_o.status", rsp.status, e.exp_status);
    check_value("rsp_o.tag", rsp.tag, e.tag);
    // Consuming edge
    @(posedge clk);
    out_ready <= 1'b0;
    @(negedge clk);
    check_value("out_valid_o", out_valid, 32'd0);
    check_value("busy_o", busy, 32'd0);
  endtask

  initial begin : main
    int unsigned stall;
    int unsigned assert_fails;
    arst_n    = 1'b0;
    req       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    void'($urandom(32'h1bb9e36f));
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    // Idle state after reset
    check_value("in_ready_o", in_ready, 32'd1);
    check_value("out_valid_o", out_valid, 32'd0);
    check_value("busy_o", busy, 32'd0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      cur_test = i;
      stall    = tests[i].rnd_stall ? 1 + ($urandom % MAX_STALL) : tests[i].stall;
      run_test(tests[i], stall);
      if (tests[i].flush_at == 0) begin
        exp_rsp_count++;
      end
    end
    @(posedge clk);
    if (rsp_count != exp_rsp_count) begin
      errors++;
      $display("Got %0d responses for %0d completed requests", rsp_count, exp_rsp_count);
    end
    assert_fails = divsqrt_multi_inst.chk_inst.fail_cnt;
    $display("Tests: %0d, check errors: %0d, assertion failures: %0d",
             NUM_TESTS, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog bound from table length and worst case per entry
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles, errors so far: %0d",
             WATCHDOG_CYCLES, errors);
    $display("Regression failed");
    $finish;
  end

endmodule

/* divsqrt_multi.f */
+incdir+hdl
hdl/divsqrt_pkg.sv
hdl/div_iter.sv
hdl/sqrt_iter.sv
hdl/divsqrt_ctrl.sv
hdl/divsqrt_multi.sv
verification/divsqrt_multi_chk.sv
verification/divsqrt_multi_tb.sv

/* Bender.yml */
package:
  name: divsqrt_multi

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/divsqrt_pkg.sv
      - hdl/div_iter.sv
      - hdl/sqrt_iter.sv
      - hdl/divsqrt_ctrl.sv
      - hdl/divsqrt_multi.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/divsqrt_multi_chk.sv
      - verification/divsqrt_multi_tb.sv
